/* common/baser_rx_pkg.sv */
// shared types of the 10GBASE-R receiver, compiled ahead of the RTL and testbench files
`default_nettype none
`include "baser_rx_settings.svh"

package baser_pkg;

    // one received block, seen as eight data bytes or as a control block
    typedef union packed {
        logic [`BASER_KEEP_W-1:0][7:0] bytes;
        struct packed {
            logic [`BASER_DATA_W-9:0] payload;
            logic [7:0]               block_type;
        } ctrl;
    } baser_block_u;

    typedef enum logic [2:0] {
        word_idle,
        word_error,
        word_start,
        word_data,
        word_term
    } word_kind_e;

    // decoded word, terminate data already shifted down and masked
    typedef struct packed {
        logic [`BASER_DATA_W-1:0] data;
        word_kind_e               kind;
        logic [2:0]               term_bytes;
    } rx_word_t;

    typedef struct packed {
        logic [`BASER_DATA_W-1:0] tdata;
        logic [`BASER_KEEP_W-1:0] tkeep;
        logic                     tvalid;
        logic                     tlast;
        logic                     tuser;
    } rx_beat_t;

    typedef struct packed {
        logic [15:0] pkt_len;
        logic        pkt_good;
        logic        pkt_bad;
        logic        err_bad_fcs;
        logic        err_oversize;
    } rx_stat_t;

endpackage

`default_nettype wire

/* common/baser_rx_settings.svh */
// widths, sync headers and block type codes for the 10GBASE-R receiver, include before use
`ifndef BASER_RX_SETTINGS_SVH
`define BASER_RX_SETTINGS_SVH

`define BASER_DATA_W 64
`define BASER_HDR_W 2
`define BASER_KEEP_W 8

`define BASER_SYNC_DATA 2'b10
`define BASER_SYNC_CTRL 2'b01

// first byte of a control block
`define BASER_BT_CTRL 8'h1e
`define BASER_BT_OS_4 8'h2d
`define BASER_BT_START_4 8'h33
`define BASER_BT_OS_04 8'h55
`define BASER_BT_OS_START 8'h66
`define BASER_BT_START_0 8'h78
`define BASER_BT_OS_0 8'h4b

// terminate, bits 6:4 give the data byte count
`define BASER_BT_TERM_0 8'h87
`define BASER_BT_TERM_1 8'h99
`define BASER_BT_TERM_2 8'haa
`define BASER_BT_TERM_3 8'hb4
`define BASER_BT_TERM_4 8'hcc
`define BASER_BT_TERM_5 8'hd2
`define BASER_BT_TERM_6 8'he1
`define BASER_BT_TERM_7 8'hff

`define BASER_MAX_PKT_LEN_DEFAULT 16'd1518

`endif

/* filelist.f */
+incdir+common
common/baser_rx_pkg.sv
hdl/baser_block_decoder.sv
hdl/baser_rx_crc.sv
hdl/baser_rx_ctrl.sv
hdl/baser_rx_top.sv
verification/baser_rx_checker.sv
verification/tb_baser_rx.sv

/* hdl/baser_block_decoder.sv */
// classifies 66-bit blocks into decoded words and flags bad blocks and framing errors
`default_nettype none
`include "baser_rx_settings.svh"

module baser_block_decoder (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire baser_pkg::baser_block_u   encoded_rx_data,
    input  wire logic [`BASER_HDR_W-1:0]   encoded_rx_hdr,
    output baser_pkg::rx_word_t            word_d0,
    output logic                           err_bad_block,
    output logic                           err_framing
);
    import baser_pkg::*;

    rx_word_t word_next;
    logic     in_frame;
    logic     in_frame_next;
    logic     bad_block_next;
    logic     framing_next;

    always_comb begin
        word_next.data = encoded_rx_data;
        word_next.kind = word_error;
        word_next.term_bytes = 3'd0;
        in_frame_next = 1'b0;
        bad_block_next = 1'b0;
        framing_next = 1'b0;

        if (encoded_rx_hdr == `BASER_SYNC_DATA) begin
            // data only expected inside a frame
            word_next.kind = word_data;
            in_frame_next = in_frame;
            framing_next = !in_frame;
        end else if (encoded_rx_hdr == `BASER_SYNC_CTRL) begin
            case (encoded_rx_data.ctrl.block_type)
                `BASER_BT_CTRL, `BASER_BT_OS_4, `BASER_BT_OS_0, `BASER_BT_OS_04: begin
                    word_next.kind = word_idle;
                    framing_next = in_frame;
                end
                `BASER_BT_START_0: begin
                    word_next.kind = word_start;
                    in_frame_next = 1'b1;
                    framing_next = in_frame;
                end
                // legal codes, but lane 4 starts are not received
                `BASER_BT_START_4, `BASER_BT_OS_START: begin
                    framing_next = in_frame;
                end
                `BASER_BT_TERM_0, `BASER_BT_TERM_1, `BASER_BT_TERM_2, `BASER_BT_TERM_3,
                `BASER_BT_TERM_4, `BASER_BT_TERM_5, `BASER_BT_TERM_6, `BASER_BT_TERM_7: begin
                    word_next.kind = word_term;
                    word_next.term_bytes = encoded_rx_data.ctrl.block_type[6:4];
                    // drop the type byte, zero the lanes after the last data byte
                    word_next.data = '0;
                    for (int i = 0; i < `BASER_KEEP_W - 1; i++) begin
                        if (i < encoded_rx_data.ctrl.block_type[6:4]) begin
                            word_next.data[8*i +: 8] = encoded_rx_data.bytes[i + 1];
                        end
                    end
                    framing_next = !in_frame;
                end
                default: begin
                    bad_block_next = 1'b1;
                end
            endcase
        end else begin
            bad_block_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        word_d0 <= word_next;
        in_frame <= in_frame_next;
        err_bad_block <= bad_block_next;
        err_framing <= framing_next;

        if (reset_crc) begin
            word_d0.kind <= word_idle;
            in_frame <= 1'b0;
            err_bad_block <= 1'b0;
            err_framing <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/baser_rx_crc.sv */
// running ethernet CRC-32 over decoded words with residue checks for each trailing byte count
`default_nettype none

module baser_rx_crc (
    input  wire logic                 clk,
    input  wire logic                 reset_crc,
    input  wire baser_pkg::rx_word_t  word_d0,
    input  wire logic                 crc_clear,
    output logic                      crc_ok_now,
    output logic                      crc_ok_saved
);
    // 04c11db7, bit reversed
    localparam logic [31:0] crc_poly_rev = 32'hedb88320;

    // expected state after a good FCS plus zero padding, index is byte count minus one
    localparam logic [7:0][31:0] crc_residue = {
        32'h2144df1c, 32'hc622f71d, 32'hb1c2a1a3, 32'h9d6cdf7e,
        32'h6522df69, 32'he60914ae, 32'he38a6876, 32'h6b87b1ec
    };

    logic [31:0] crc_state;
    logic [31:0] crc_next;
    logic [7:0]  crc_valid;
    logic [7:0]  crc_valid_save;
    logic [2:0]  sel_now;
    logic [2:0]  sel_save;

    function automatic logic [31:0] crc32_word(input logic [31:0] state, input logic [63:0] data);
        logic [31:0] c;
        c = state;
        for (int i = 0; i < 64; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ crc_poly_rev;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_comb begin
        crc_next = crc32_word(crc_state, word_d0.data);
        for (int i = 0; i < 8; i++) begin
            crc_valid[i] = crc_next == ~crc_residue[i];
        end
    end

    // a count of zero wraps round to the full-word check
    assign sel_now = word_d0.term_bytes - 3'd1;
    assign crc_ok_now = crc_valid[sel_now];
    assign crc_ok_saved = crc_valid_save[sel_save];

    always_ff @(posedge clk) begin
        if (crc_clear) begin
            crc_state <= '1;
        end else begin
            crc_state <= crc_next;
        end
        crc_valid_save <= crc_valid;
        sel_save <= sel_now;

        if (reset_crc) begin
            crc_state <= '1;
        end
    end

endmodule

`default_nettype wire

/* hdl/baser_rx_ctrl.sv */
// frame state machine of the receiver, builds output beats and per-frame status
`default_nettype none
`include "baser_rx_settings.svh"

module baser_rx_ctrl (
    input  wire logic                 clk,
    input  wire logic                 reset_crc,
    input  wire baser_pkg::rx_word_t  word_d0,
    input  wire logic                 crc_ok_now,
    input  wire logic                 crc_ok_saved,
    input  wire logic [15:0]          cfg_rx_max_pkt_len,
    input  wire logic                 cfg_rx_enable,
    output logic                      crc_clear,
    output baser_pkg::rx_beat_t       m_rx,
    output baser_pkg::rx_stat_t       stat
);
    import baser_pkg::*;

    localparam logic [1:0] state_idle = 2'd0;
    localparam logic [1:0] state_payload = 2'd1;
    localparam logic [1:0] state_last = 2'd2;

    logic [1:0]  state;
    logic [1:0]  state_next;
    rx_word_t    word_d1;
    logic [15:0] frame_len;
    logic [15:0] frame_len_next;
    logic [15:0] frame_len_lim;
    logic [15:0] frame_len_lim_next;
    logic        frame_oversize;
    logic        frame_oversize_next;
    rx_beat_t    beat_next;
    rx_stat_t    stat_next;
    logic        end_frame;
    logic        end_crc_ok;
    logic        end_oversize;
    logic [15:0] end_len;

    always_comb begin
        state_next = state_idle;
        crc_clear = 1'b0;
        frame_len_next = frame_len;
        frame_len_lim_next = frame_len_lim;
        frame_oversize_next = frame_oversize;
        beat_next = '0;
        beat_next.tdata = word_d1.data;
        stat_next = '0;
        end_frame = 1'b0;
        end_crc_ok = 1'b0;
        end_oversize = frame_oversize;
        end_len = frame_len;

        // byte count, saturating
        if (frame_len[15:3] != '1) begin
            if (word_d0.kind == word_term) begin
                frame_len_next = frame_len + 16'(word_d0.term_bytes);
            end else begin
                frame_len_next = frame_len + 16'(`BASER_KEEP_W);
            end
        end else begin
            frame_len_next = '1;
        end

        // remaining allowance
        if (frame_len_lim[15:3] != '0) begin
            frame_len_lim_next = frame_len_lim - 16'(`BASER_KEEP_W);
        end else begin
            frame_len_lim_next = '0;
        end

        case (state)
            state_idle: begin
                crc_clear = 1'b1;
                frame_len_next = 16'(`BASER_KEEP_W);
                frame_len_lim_next = cfg_rx_max_pkt_len;
                // start word holds the preamble, CRC begins with the next word
                if (word_d1.kind == word_start && cfg_rx_enable) begin
                    crc_clear = 1'b0;
                    state_next = state_payload;
                end
            end
            state_payload: begin
                beat_next.tkeep = '1;
                beat_next.tvalid = 1'b1;
                if (word_d0.kind == word_term) begin
                    frame_oversize_next =
                        frame_len_lim < 16'(`BASER_KEEP_W) + 16'(word_d0.term_bytes);
                end else begin
                    frame_oversize_next = frame_len_lim < 16'(`BASER_KEEP_W);
                end

                if (word_d0.kind == word_data) begin
                    state_next = state_payload;
                end else if (word_d0.kind == word_term) begin
                    crc_clear = 1'b1;
                    if (word_d0.term_bytes <= 3'd4) begin
                        // FCS ends inside the word in d1
                        beat_next.tkeep = 8'hff >> (3'd4 - word_d0.term_bytes);
                        beat_next.tlast = 1'b1;
                        end_frame = 1'b1;
                        end_crc_ok = (word_d0.term_bytes == 3'd0) ? crc_ok_saved : crc_ok_now;
                        end_oversize = frame_oversize_next;
                        end_len = frame_len_next;
                    end else begin
                        state_next = state_last;
                    end
                end else begin
                    // control or error word cuts the frame short
                    crc_clear = 1'b1;
                    beat_next.tlast = 1'b1;
                    beat_next.tuser = 1'b1;
                    stat_next.pkt_bad = 1'b1;
                    stat_next.pkt_len = frame_len_next;
                    stat_next.err_oversize = frame_oversize_next;
                end
            end
            state_last: begin
                // leftover 1 to 3 bytes of the terminate word
                crc_clear = 1'b1;
                beat_next.tkeep = 8'hff >> (4'd12 - 4'(word_d1.term_bytes));
                beat_next.tvalid = 1'b1;
                beat_next.tlast = 1'b1;
                end_frame = 1'b1;
                end_crc_ok = crc_ok_saved;
            end
            default: begin
                state_next = state_idle;
            end
        endcase

        if (end_frame) begin
            stat_next.pkt_len = end_len;
            stat_next.err_oversize = end_oversize;
            if (!end_crc_ok) begin
                beat_next.tuser = 1'b1;
                stat_next.pkt_bad = 1'b1;
                stat_next.err_bad_fcs = 1'b1;
            end else if (end_oversize) begin
                beat_next.tuser = 1'b1;
                stat_next.pkt_bad = 1'b1;
            end else begin
                stat_next.pkt_good = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        state <= state_next;
        word_d1 <= word_d0;
        frame_len <= frame_len_next;
        frame_len_lim <= frame_len_lim_next;
        frame_oversize <= frame_oversize_next;
        m_rx <= beat_next;
        stat <= stat_next;

        if (reset_crc) begin
            state <= state_idle;
            word_d1.kind <= word_idle;
            frame_oversize <= 1'b0;
            m_rx.tvalid <= 1'b0;
            stat <= '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/baser_rx_top.sv */
// 10GBASE-R frame receiver top level, 66-bit blocks in and frame beats with status out
`default_nettype none
`include "baser_rx_settings.svh"

module baser_rx_top (
    input  wire logic                      clk,
    input  wire logic                      reset_crc,
    input  wire baser_pkg::baser_block_u   encoded_rx_data,
    input  wire logic [`BASER_HDR_W-1:0]   encoded_rx_hdr,
    input  wire logic [15:0]               cfg_rx_max_pkt_len,
    input  wire logic                      cfg_rx_enable,
    output wire baser_pkg::rx_beat_t       m_rx,
    output wire baser_pkg::rx_stat_t       stat,
    output wire logic                      err_bad_block,
    output wire logic                      err_framing
);
    import baser_pkg::*;

    wire rx_word_t word_d0;
    wire logic     crc_clear;
    wire logic     crc_ok_now;
    wire logic     crc_ok_saved;

    baser_block_decoder i_decoder (
        .clk             (clk),
        .reset_crc       (reset_crc),
        .encoded_rx_data (encoded_rx_data),
        .encoded_rx_hdr  (encoded_rx_hdr),
        .word_d0         (word_d0),
        .err_bad_block   (err_bad_block),
        .err_framing     (err_framing)
    );

    baser_rx_crc i_crc (
        .clk          (clk),
        .reset_crc    (reset_crc),
        .word_d0      (word_d0),
        .crc_clear    (crc_clear),
        .crc_ok_now   (crc_ok_now),
        .crc_ok_saved (crc_ok_saved)
    );

    baser_rx_ctrl i_ctrl (
        .clk                (clk),
        .reset_crc          (reset_crc),
        .word_d0            (word_d0),
        .crc_ok_now         (crc_ok_now),
        .crc_ok_saved       (crc_ok_saved),
        .cfg_rx_max_pkt_len (cfg_rx_max_pkt_len),
        .cfg_rx_enable      (cfg_rx_enable),
        .crc_clear          (crc_clear),
        .m_rx               (m_rx),
        .stat               (stat)
    );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_baser_rx -o sim_baser_rx
./obj_dir/sim_baser_rx | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
grep -q "ALL CHECKS PASSED" sim.log
echo "simulation passed"

/* verification/baser_rx_checker.sv */
// watches the receiver outputs, rebuilds each frame and compares it with the expected result
`default_nettype none
`include "baser_rx_settings.svh"

module baser_rx_checker (
    input wire logic                clk,
    input wire logic                reset_crc,
    input wire baser_pkg::rx_beat_t m_rx,
    input wire baser_pkg::rx_stat_t stat,
    input wire logic                err_bad_block,
    input wire logic                err_framing,
    input wire logic                report
);
    timeunit 1ns;
    timeprecision 1ps;
    import baser_pkg::*;

    typedef struct packed {
        logic [15:0] nbytes;
        logic        tuser;
        logic        check_len;
        rx_stat_t    stat;
    } expect_t;

    // filled by the frame builder
    logic [7:0]  sent_bytes[$];
    int          frame_len_q[$];
    logic        fcs_flip_q[$];
    int          cut_words_q[$];
    logic [15:0] max_len_q[$];
    int          framing_expected = 0;
    int          bad_block_expected = 0;

    logic [7:0]  rx_bytes[$];
    int          data_errors = 0;
    int          status_errors = 0;
    int          other_errors = 0;
    int          frames_checked = 0;
    int          framing_seen = 0;
    int          bad_block_seen = 0;

    function automatic expect_t expected_result(input int len, input logic flip, input int cut,
                                                input logic [15:0] max_len);
        expect_t e;
        int      frame_bytes;
        e = '0;
        frame_bytes = len + 4;
        if (cut > 0) begin
            // a frame cut short before the FCS keeps every word received so far
            e.nbytes = 16'(8 * cut);
            e.tuser = 1'b1;
            e.stat.pkt_bad = 1'b1;
        end else begin
            e.nbytes = 16'(len);
            e.check_len = 1'b1;
            e.stat.pkt_len = 16'(frame_bytes);
            e.stat.err_bad_fcs = flip;
            e.stat.err_oversize = frame_bytes > int'(max_len);
            e.stat.pkt_bad = flip || e.stat.err_oversize;
            e.stat.pkt_good = !e.stat.pkt_bad;
            e.tuser = e.stat.pkt_bad;
        end
        return e;
    endfunction

    task automatic compare_field(input string name, input int expected, input int actual);
        if (expected != actual) begin
            status_errors++;
            $display("Fail at %0t: %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_frame();
        expect_t    e;
        int         len;
        logic [7:0] sent;
        int         mismatches;
        len = frame_len_q.pop_front();
        e = expected_result(len, fcs_flip_q.pop_front(), cut_words_q.pop_front(),
                            max_len_q.pop_front());
        if (rx_bytes.size() != int'(e.nbytes)) begin
            data_errors++;
            $display("Fail at %0t: m_rx.tkeep byte count expected %0d got %0d",
                     $time, e.nbytes, rx_bytes.size());
        end
        mismatches = 0;
        for (int i = 0; i < len; i++) begin
            sent = sent_bytes.pop_front();
            if (i < int'(e.nbytes) && i < rx_bytes.size() && rx_bytes[i] != sent) begin
                if (mismatches == 0) begin
                    $display("Fail at %0t: m_rx.tdata byte %0d expected %h got %h",
                             $time, i, sent, rx_bytes[i]);
                end
                mismatches++;
            end
        end
        if (mismatches != 0) begin
            data_errors++;
        end
        rx_bytes.delete();
        compare_field("m_rx.tuser", int'(e.tuser), int'(m_rx.tuser));
        compare_field("stat.pkt_good", int'(e.stat.pkt_good), int'(stat.pkt_good));
        compare_field("stat.pkt_bad", int'(e.stat.pkt_bad), int'(stat.pkt_bad));
        compare_field("stat.err_bad_fcs", int'(e.stat.err_bad_fcs), int'(stat.err_bad_fcs));
        compare_field("stat.err_oversize", int'(e.stat.err_oversize), int'(stat.err_oversize));
        if (e.check_len) begin
            compare_field("stat.pkt_len", int'(e.stat.pkt_len), int'(stat.pkt_len));
        end
        frames_checked++;
    endtask

    always @(negedge clk) begin
        if (!reset_crc) begin
            if (err_framing) begin
                framing_seen++;
            end
            if (err_bad_block) begin
                bad_block_seen++;
            end
            if ((stat.pkt_good || stat.pkt_bad) && !(m_rx.tvalid && m_rx.tlast)) begin
                other_errors++;
                $display("status pulse at %0t without a last beat", $time);
            end
            if (m_rx.tvalid && frame_len_q.size() == 0) begin
                other_errors++;
                $display("beat at %0t while no frame was expected", $time);
            end else if (m_rx.tvalid) begin
                for (int j = 0; j < `BASER_KEEP_W; j++) begin
                    if (m_rx.tkeep[j]) begin
                        rx_bytes.push_back(m_rx.tdata[8*j +: 8]);
                    end
                end
                if (m_rx.tlast) begin
                    check_frame();
                end
            end
        end
    end

    always @(posedge report) begin
        if (frame_len_q.size() != 0) begin
            other_errors++;
            $display("%0d expected frames never arrived", frame_len_q.size());
        end
        if (framing_seen != framing_expected) begin
            other_errors++;
            $display("Fail at %0t: err_framing pulses expected %0d got %0d",
                     $time, framing_expected, framing_seen);
        end
        if (bad_block_seen != bad_block_expected) begin
            other_errors++;
            $display("Fail at %0t: err_bad_block pulses expected %0d got %0d",
                     $time, bad_block_expected, bad_block_seen);
        end
        $display("error counts: data %0d, status %0d, other %0d, over %0d frames",
                 data_errors, status_errors, other_errors, frames_checked);
    end

endmodule

`default_nettype wire

/* verification/tb_baser_rx.sv */
// testbench top for the 10GBASE-R receiver, encodes random frames into 66-bit blocks for the DUT
`default_nettype none
`include "baser_rx_settings.svh"

module tb_baser_rx;
    timeunit 1ns;
    timeprecision 1ps;
    import baser_pkg::*;

    localparam int n_good = 16;
    localparam int n_frames = n_good + 7;
    // start, up to 25 data words, terminate
    localparam int max_blocks = (200 + 4) / 8 + 2;
    localparam int timeout_cycles = n_frames * (max_blocks + 20);
    localparam int gap_blocks = 4;

    logic                    clk;
    logic                    reset_crc;
    baser_block_u            encoded_rx_data;
    logic [`BASER_HDR_W-1:0] encoded_rx_hdr;
    logic [15:0]             cfg_rx_max_pkt_len;
    logic                    cfg_rx_enable;
    logic                    report;
    rx_beat_t                m_rx;
    rx_stat_t                stat;
    logic                    err_bad_block;
    logic                    err_framing;
    logic [31:0]             lcg_state;
    int                      cycle_count;

    baser_rx_top i_baser_rx_top (
        .clk                (clk),
        .reset_crc          (reset_crc),
        .encoded_rx_data    (encoded_rx_data),
        .encoded_rx_hdr     (encoded_rx_hdr),
        .cfg_rx_max_pkt_len (cfg_rx_max_pkt_len),
        .cfg_rx_enable      (cfg_rx_enable),
        .m_rx               (m_rx),
        .stat               (stat),
        .err_bad_block      (err_bad_block),
        .err_framing        (err_framing)
    );

    baser_rx_checker i_checker (
        .clk           (clk),
        .reset_crc     (reset_crc),
        .m_rx          (m_rx),
        .stat          (stat),
        .err_bad_block (err_bad_block),
        .err_framing   (err_framing),
        .report        (report)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:8]) % n;
    endfunction

    // reflected ethernet CRC, one byte LSB first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            c = (c[0] ^ b[i]) ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
        end
        return c;
    endfunction

    function automatic logic [7:0] term_code(input int n);
        case (n)
            0: return `BASER_BT_TERM_0;
            1: return `BASER_BT_TERM_1;
            2: return `BASER_BT_TERM_2;
            3: return `BASER_BT_TERM_3;
            4: return `BASER_BT_TERM_4;
            5: return `BASER_BT_TERM_5;
            6: return `BASER_BT_TERM_6;
            default: return `BASER_BT_TERM_7;
        endcase
    endfunction

    task automatic send_block(input logic [`BASER_HDR_W-1:0] hdr, input baser_block_u blk);
        @(negedge clk);
        encoded_rx_hdr = hdr;
        encoded_rx_data = blk;
    endtask

    task automatic send_idle();
        baser_block_u blk;
        blk = '0;
        blk.ctrl.block_type = `BASER_BT_CTRL;
        send_block(`BASER_SYNC_CTRL, blk);
    endtask

    // cut_words above zero stops the frame after that many data blocks, no terminate
    task automatic send_frame(input int len, input logic flip_fcs, input int cut_words,
                              input logic expected);
        logic [7:0]   frame[$];
        logic [31:0]  crc;
        logic [31:0]  r;
        baser_block_u blk;
        int           n_words;
        int           n_term;
        crc = '1;
        for (int i = 0; i < len; i++) begin
            r = lcg_next();
            frame.push_back(r[23:16]);
            crc = crc32_byte(crc, r[23:16]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            frame.push_back(crc[8*i +: 8]);
        end
        if (flip_fcs) begin
            frame[len] = ~frame[len];
        end
        if (expected) begin
            for (int i = 0; i < len; i++) begin
                i_checker.sent_bytes.push_back(frame[i]);
            end
            i_checker.frame_len_q.push_back(len);
            i_checker.fcs_flip_q.push_back(flip_fcs);
            i_checker.cut_words_q.push_back(cut_words);
            i_checker.max_len_q.push_back(cfg_rx_max_pkt_len);
        end

        // lane 0 is the type byte, then preamble and SFD
        blk = '0;
        blk.ctrl.block_type = `BASER_BT_START_0;
        for (int i = 1; i < 7; i++) begin
            blk.bytes[i] = 8'h55;
        end
        blk.bytes[7] = 8'hd5;
        send_block(`BASER_SYNC_CTRL, blk);

        n_words = (cut_words > 0) ? cut_words : (len + 4) / 8;
        n_term = (len + 4) % 8;
        for (int w = 0; w < n_words; w++) begin
            for (int j = 0; j < 8; j++) begin
                blk.bytes[j] = frame[8*w + j];
            end
            send_block(`BASER_SYNC_DATA, blk);
        end
        if (cut_words == 0) begin
            blk = '0;
            blk.ctrl.block_type = term_code(n_term);
            for (int i = 0; i < n_term; i++) begin
                blk.bytes[i + 1] = frame[8*n_words + i];
            end
            send_block(`BASER_SYNC_CTRL, blk);
        end
        repeat (gap_blocks) send_idle();
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, frames still outstanding", cycle_count);
        report = 1'b1;
        #1;
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        baser_block_u blk;
        lcg_state = 32'h7294_3fa0;
        reset_crc = 1'b1;
        encoded_rx_hdr = `BASER_SYNC_CTRL;
        encoded_rx_data = '0;
        encoded_rx_data.ctrl.block_type = `BASER_BT_CTRL;
        cfg_rx_max_pkt_len = `BASER_MAX_PKT_LEN_DEFAULT;
        cfg_rx_enable = 1'b1;
        report = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_crc = 1'b0;
        repeat (gap_blocks) send_idle();

        // length chosen so that each terminate byte count comes up twice
        for (int i = 0; i < n_good; i++) begin
            send_frame(64 + 8 * rand_below(16) + (i + 4) % 8, 1'b0, 0, 1'b1);
        end
        send_frame(100, 1'b1, 0, 1'b1);

        // limit of 100 bytes, one frame above and one exactly at it
        cfg_rx_max_pkt_len = 16'd100;
        send_frame(120, 1'b0, 0, 1'b1);
        send_frame(96, 1'b0, 0, 1'b1);
        cfg_rx_max_pkt_len = `BASER_MAX_PKT_LEN_DEFAULT;

        // idle after five data words
        send_frame(150, 1'b0, 5, 1'b1);
        i_checker.framing_expected++;
        blk = '0;
        send_block(`BASER_SYNC_CTRL, blk);
        i_checker.bad_block_expected++;
        repeat (gap_blocks) send_idle();

        cfg_rx_enable = 1'b0;
        send_frame(80, 1'b0, 0, 1'b0);
        cfg_rx_enable = 1'b1;
        send_frame(72, 1'b0, 0, 1'b1);
        send_frame(131, 1'b0, 0, 1'b1);

        while (i_checker.frame_len_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (gap_blocks) @(negedge clk);
        report = 1'b1;
        @(negedge clk);
        if (i_checker.data_errors + i_checker.status_errors + i_checker.other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
